// ==== flash_pkg.sv ====
// SPI flash controller definitions
`default_nettype none

package flash_pkg;

	////////////////////////////////////////////////////////////
	// Flash opcodes
	////////////////////////////////////////////////////////////

	// Only the slow single-bit read is issued by the controller
	typedef enum logic [7:0]
	{
		CMD_READ = 8'h03
	} flash_cmd_e;

	////////////////////////////////////////////////////////////
	// Sequencer states
	////////////////////////////////////////////////////////////

	typedef enum logic [1:0]
	{
		ST_IDLE,
		ST_READ,
		ST_USER_IDLE,
		ST_USER_XFER
	} seq_state_e;

	// Countdown width, large enough for a full read frame
	localparam int unsigned CNT_W = 7;

	// 8 opcode + 24 address + 32 data bits, plus the capture clock
	localparam logic [CNT_W-1:0] READ_LEN = 7'd65;
	// One user byte plus its capture clock
	localparam logic [CNT_W-1:0] USER_LEN = 7'd9;

	// Bus data width
	localparam int unsigned DATA_W = 32;

endpackage

`default_nettype wire

// ==== flash_seq.sv ====
// Flash transfer sequencer
`timescale 1ns/1ps
`default_nettype none

module flash_seq
(
	input  logic i_clk,
	input  logic i_reset,
	// Bus request side
	input  logic i_wb_cyc,
	input  logic i_wb_stb,
	input  logic i_cfg_stb,
	input  logic i_wb_we,
	// Bit 8 of the control word, high releases chip select
	input  logic i_cfg_cs_n,
	output logic o_wb_stall,
	output logic o_wb_ack,
	// SPI framing pins
	output logic o_spi_cs_n,
	output logic o_spi_sck,
	// Controls towards the shifter
	output logic o_start_read,
	output logic o_start_user,
	output logic o_capture,
	output logic o_user_mode
);
	import flash_pkg::*;

	seq_state_e       state;
	logic [CNT_W-1:0] count;
	logic             accept_mem;
	logic             accept_cfg;
	logic             read_req;
	logic             user_req;
	logic             mode_exit;
	logic             imm_req;
	logic             imm_ack;
	logic             last_cnt;

	////////////////////////////////////////////////////////////
	// Request decode
	////////////////////////////////////////////////////////////

	// A strobe is taken only while not stalled
	assign accept_mem = i_wb_cyc && i_wb_stb && !o_wb_stall;
	assign accept_cfg = i_wb_cyc && i_cfg_stb && !o_wb_stall;

	// Memory read runs a full frame unless the port is in user mode
	assign read_req  = accept_mem && !i_wb_we && !o_user_mode;
	// Control write with CS_n low sends one byte
	assign user_req  = accept_cfg && i_wb_we && !i_cfg_cs_n;
	// Control write with CS_n high leaves user mode
	assign mode_exit = accept_cfg && i_wb_we && i_cfg_cs_n;
	// Everything else is answered on the next clock
	assign imm_req   = (accept_mem || accept_cfg) && !read_req && !user_req;

	// Final clock of a running frame
	assign last_cnt = (count == CNT_W'(1));

	assign o_user_mode = (state == ST_USER_IDLE) || (state == ST_USER_XFER);

	// Mode and frame tracking
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			state <= ST_IDLE;
		else
		begin
			case (state)
			ST_IDLE:
				if (read_req)
					state <= ST_READ;
				else if (user_req)
					state <= ST_USER_XFER;
			ST_READ:
				// Abort or frame done both return to idle
				if (!i_wb_cyc || last_cnt)
					state <= ST_IDLE;
			ST_USER_IDLE:
				if (mode_exit)
					state <= ST_IDLE;
				else if (user_req)
					state <= ST_USER_XFER;
			ST_USER_XFER:
				// User mode survives a bus abort
				if (!i_wb_cyc || last_cnt)
					state <= ST_USER_IDLE;
			default:
				state <= ST_IDLE;
			endcase
		end
	end

	// Start pulses, one clock after acceptance
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			o_start_read <= 1'b0;
			o_start_user <= 1'b0;
			imm_ack      <= 1'b0;
		end
		else
		begin
			o_start_read <= read_req;
			o_start_user <= user_req;
			imm_ack      <= imm_req;
		end
	end

	////////////////////////////////////////////////////////////
	// Countdown and derived bus/SPI strobes
	////////////////////////////////////////////////////////////

	// Loaded together with the shifter, then runs down to zero
	always_ff @(posedge i_clk)
	begin
		if (i_reset || !i_wb_cyc)
			count <= '0;
		else if (o_start_read)
			count <= READ_LEN;
		else if (o_start_user)
			count <= USER_LEN;
		else if (count != '0)
			count <= count - 1'b1;
	end

	// Held from acceptance until the countdown reaches one
	always_ff @(posedge i_clk)
	begin
		if (i_reset || !i_wb_cyc)
			o_wb_stall <= 1'b0;
		else if (read_req || user_req || o_start_read || o_start_user)
			o_wb_stall <= 1'b1;
		else
			o_wb_stall <= (count > CNT_W'(1));
	end

	// One clock per bit, the last countdown step is capture only
	always_ff @(posedge i_clk)
	begin
		if (i_reset || !i_wb_cyc)
			o_spi_sck <= 1'b0;
		else
			o_spi_sck <= o_start_read || o_start_user || (count > CNT_W'(2));
	end

	// MISO is valid one clock behind the serial clock
	always_ff @(posedge i_clk)
	begin
		if (i_reset || !i_wb_cyc)
			o_capture <= 1'b0;
		else
			o_capture <= o_spi_sck;
	end

	// Frame end or the delayed immediate answer
	always_ff @(posedge i_clk)
	begin
		if (i_reset || !i_wb_cyc)
			o_wb_ack <= 1'b0;
		else
			o_wb_ack <= last_cnt || imm_ack;
	end

	// Chip select
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			o_spi_cs_n <= 1'b1;
		else if (!i_wb_cyc && !o_user_mode)
			o_spi_cs_n <= 1'b1;
		else if (read_req || user_req)
			o_spi_cs_n <= 1'b0;
		else if (mode_exit)
			o_spi_cs_n <= 1'b1;
		else if ((state == ST_READ) && last_cnt)
			// rises with the read acknowledge
			o_spi_cs_n <= 1'b1;
	end

endmodule

`default_nettype wire

// ==== flash_shift.sv ====
// Flash command and data shifter
`timescale 1ns/1ps
`default_nettype none

module flash_shift
#(
	// Word address bits, at most 22
	parameter int ADDR_W = 22
)
(
	input  logic                        i_clk,
	// Frame starts from the sequencer
	input  logic                        i_start_read,
	input  logic                        i_start_user,
	input  logic                        i_capture,
	input  logic                        i_user_mode,
	// Request fields straight from the bus
	input  logic [ADDR_W-1:0]           i_addr,
	input  logic [7:0]                  i_byte,
	// Serial pins
	input  logic                        i_spi_miso,
	output logic                        o_spi_mosi,
	output logic [flash_pkg::DATA_W-1:0] o_wb_data
);
	import flash_pkg::*;

	logic [ADDR_W-1:0] addr_q;
	logic [7:0]        byte_q;
	logic [23:0]       byte_addr;
	logic [32:0]       shift_q;

	////////////////////////////////////////////////////////////
	// Outgoing command
	////////////////////////////////////////////////////////////

	// Bus fields sampled on the accepting edge
	// The start pulse arrives one clock later
	always_ff @(posedge i_clk)
	begin
		addr_q <= i_addr;
		byte_q <= i_byte;
	end

	// Word address to byte address, zero filled above
	assign byte_addr = 24'({addr_q, 2'b00});

	// Opcode and address leave first, trailing zero fills the data phase
	always_ff @(posedge i_clk)
	begin
		if (i_start_read)
			shift_q <= {CMD_READ, byte_addr, 1'b0};
		else if (i_start_user)
			shift_q <= {byte_q, 25'd0};
		else
			shift_q <= {shift_q[31:0], 1'b0};
	end

	// MSB first
	assign o_spi_mosi = shift_q[32];

	////////////////////////////////////////////////////////////
	// Incoming data
	////////////////////////////////////////////////////////////

	// Shifts on capture clocks only
	// In user mode the word holds just the last byte read
	always_ff @(posedge i_clk)
	begin
		if (i_capture)
		begin
			if (i_user_mode)
				o_wb_data <= {{(DATA_W-8){1'b0}}, o_wb_data[6:0], i_spi_miso};
			else
				o_wb_data <= {o_wb_data[DATA_W-2:0], i_spi_miso};
		end
		else if (i_user_mode)
			// upper bits read as zero on the control port
			o_wb_data[DATA_W-1:8] <= '0;
	end

endmodule

`default_nettype wire

// ==== spi_flash_ctrl.sv ====
// SPI flash read controller
`timescale 1ns/1ps
`default_nettype none

module spi_flash_ctrl
#(
	// Word address width of the flash
	parameter int ADDR_W = 22
)
(
	input  logic                         i_clk,
	input  logic                         i_reset,
	// Pipelined bus slave
	input  logic                         i_wb_cyc,
	input  logic                         i_wb_stb,
	input  logic                         i_cfg_stb,
	input  logic                         i_wb_we,
	input  logic [ADDR_W-1:0]            i_wb_addr,
	input  logic [flash_pkg::DATA_W-1:0] i_wb_data,
	output logic                         o_wb_stall,
	output logic                         o_wb_ack,
	output logic [flash_pkg::DATA_W-1:0] o_wb_data,
	// SPI flash pins
	output logic                         o_spi_cs_n,
	output logic                         o_spi_sck,
	output logic                         o_spi_mosi,
	input  logic                         i_spi_miso
);

	// Sequencer to shifter
	logic start_read;
	logic start_user;
	logic capture;
	logic user_mode;

	// Decode, countdown and pin framing
	flash_seq seq_inst
	(
		.i_clk        (i_clk),
		.i_reset      (i_reset),
		.i_wb_cyc     (i_wb_cyc),
		.i_wb_stb     (i_wb_stb),
		.i_cfg_stb    (i_cfg_stb),
		.i_wb_we      (i_wb_we),
		.i_cfg_cs_n   (i_wb_data[8]),
		.o_wb_stall   (o_wb_stall),
		.o_wb_ack     (o_wb_ack),
		.o_spi_cs_n   (o_spi_cs_n),
		.o_spi_sck    (o_spi_sck),
		.o_start_read (start_read),
		.o_start_user (start_user),
		.o_capture    (capture),
		.o_user_mode  (user_mode)
	);

	// MOSI command path and MISO data word
	flash_shift
	#(
		.ADDR_W (ADDR_W)
	)
	shift_inst
	(
		.i_clk        (i_clk),
		.i_start_read (start_read),
		.i_start_user (start_user),
		.i_capture    (capture),
		.i_user_mode  (user_mode),
		.i_addr       (i_wb_addr),
		.i_byte       (i_wb_data[7:0]),
		.i_spi_miso   (i_spi_miso),
		.o_spi_mosi   (o_spi_mosi),
		.o_wb_data    (o_wb_data)
	);

endmodule

`default_nettype wire

// ==== spi_flash_ctrl_chk.sv ====
// SPI flash controller protocol checker
`timescale 1ns/1ps
`default_nettype none

module spi_flash_ctrl_chk
(
	input logic i_clk,
	input logic i_reset,
	input logic i_wb_cyc,
	input logic i_wb_stb,
	input logic i_cfg_stb,
	input logic i_wb_stall,
	input logic i_wb_ack,
	input logic i_spi_cs_n,
	input logic i_spi_sck,
	input logic i_user_mode
);
	import flash_pkg::*;

	logic        accept;
	logic [1:0]  pending;
	logic [7:0]  ack_wait;
	// Assertion failures so far
	int unsigned fail_count = 0;

	assign accept = i_wb_cyc && (i_wb_stb || i_cfg_stb) && !i_wb_stall;

	// Requests taken but not yet acknowledged, and how long the oldest waits
	always_ff @(posedge i_clk)
	begin
		if (i_reset || !i_wb_cyc)
		begin
			pending  <= '0;
			ack_wait <= '0;
		end
		else
		begin
			pending  <= pending + 2'(accept) - 2'(i_wb_ack);
			ack_wait <= (i_wb_ack || (pending == '0)) ? 8'd0 : ack_wait + 8'd1;
		end
	end

	////////////////////////////////////////////////////////////
	// Properties
	////////////////////////////////////////////////////////////

	// SCK only inside a frame
	sck_in_frame: assert property (@(posedge i_clk) disable iff (i_reset)
		i_spi_sck |-> !i_spi_cs_n)
	else
	begin
		$error("serial clock high while chip select high");
		fail_count++;
	end

	// No acknowledge without a request
	ack_has_req: assert property (@(posedge i_clk) disable iff (i_reset)
		i_wb_ack |-> (pending != 2'd0))
	else
	begin
		$error("acknowledge without an accepted request");
		fail_count++;
	end

	// Every request is answered within one read frame
	ack_in_time: assert property (@(posedge i_clk) disable iff (i_reset)
		ack_wait <= 8'(READ_LEN + 2))
	else
	begin
		$error("accepted request was never acknowledged");
		fail_count++;
	end

	// Idle pins one clock after reset
	reset_state: assert property (@(posedge i_clk)
		i_reset |=> (i_spi_cs_n && !i_wb_stall && !i_wb_ack && !i_spi_sck))
	else
	begin
		$error("outputs not idle after reset");
		fail_count++;
	end

	// Bus abort outside user mode ends the frame
	abort_frame: assert property (@(posedge i_clk) disable iff (i_reset)
		(!i_wb_cyc && i_wb_stall && !i_user_mode) |=> (!i_wb_stall && i_spi_cs_n))
	else
	begin
		$error("abort did not release stall and chip select");
		fail_count++;
	end

endmodule

`default_nettype wire

// ==== tb_spi_flash_ctrl.sv ====
// SPI flash controller testbench
`timescale 1ns/1ps
`default_nettype none

module tb_spi_flash_ctrl;
	import flash_pkg::*;

	localparam int ADDR_W  = 22;
	localparam int TIMEOUT = 100;

	logic              clk = 1'b0;
	logic              reset;
	logic              wb_cyc;
	logic              wb_stb;
	logic              cfg_stb;
	logic              wb_we;
	logic [ADDR_W-1:0] wb_addr;
	logic [DATA_W-1:0] wb_wdata;
	logic              wb_stall;
	logic              wb_ack;
	logic [DATA_W-1:0] wb_rdata;
	logic              spi_cs_n;
	logic              spi_sck;
	logic              spi_mosi;
	logic              spi_miso;
	// Flash model state
	logic              in_user;
	logic              miso_next;
	logic [31:0]       hdr;
	logic [31:0]       word;
	int                slot = 0;
	logic [31:0]       rng_state = 32'd32138;

	always #10 clk = ~clk;

	spi_flash_ctrl #(.ADDR_W(ADDR_W)) spi_flash_ctrl_inst
	(
		.i_clk      (clk),
		.i_reset    (reset),
		.i_wb_cyc   (wb_cyc),
		.i_wb_stb   (wb_stb),
		.i_cfg_stb  (cfg_stb),
		.i_wb_we    (wb_we),
		.i_wb_addr  (wb_addr),
		.i_wb_data  (wb_wdata),
		.o_wb_stall (wb_stall),
		.o_wb_ack   (wb_ack),
		.o_wb_data  (wb_rdata),
		.o_spi_cs_n (spi_cs_n),
		.o_spi_sck  (spi_sck),
		.o_spi_mosi (spi_mosi),
		.i_spi_miso (spi_miso)
	);

	bind spi_flash_ctrl spi_flash_ctrl_chk chk_inst
	(
		.i_clk       (i_clk),
		.i_reset     (i_reset),
		.i_wb_cyc    (i_wb_cyc),
		.i_wb_stb    (i_wb_stb),
		.i_cfg_stb   (i_cfg_stb),
		.i_wb_stall  (o_wb_stall),
		.i_wb_ack    (o_wb_ack),
		.i_spi_cs_n  (o_spi_cs_n),
		.i_spi_sck   (o_spi_sck),
		.i_user_mode (user_mode)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] next_rand();
		rng_state = xorshift(rng_state);
		return rng_state;
	endfunction

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("test failed");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got == exp)
		else
			stop_on_error($sformatf("ERR %s got %08h expected %08h", name, got, exp));
	endtask

	// Strobe held until an edge sees no stall
	task automatic issue_request(input logic cfg, input logic we,
		input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d);
		int n;
		n = 0;
		wb_stb   = !cfg;
		cfg_stb  = cfg;
		wb_we    = we;
		wb_addr  = a;
		wb_wdata = d;
		do
		begin
			@(posedge clk);
			n++;
			if (n > TIMEOUT)
				stop_on_error("request was not accepted before the timeout");
		end
		while (wb_stall);
		#1;
		wb_stb  = 1'b0;
		cfg_stb = 1'b0;
	endtask

	// Whole request with latency, stall, idle SCK and final chip select
	task automatic bus_xfer(input logic cfg, input logic we, input logic [ADDR_W-1:0] a,
		input logic [DATA_W-1:0] d, input int lat, input logic cs_n);
		int k;
		k = 0;
		issue_request(cfg, we, a, d);
		do
		begin
			@(posedge clk);
			k++;
			if (k > TIMEOUT)
				stop_on_error("no acknowledge arrived before the timeout");
			if (!wb_ack)
			begin
				check_value("o_wb_stall", wb_stall, 32'(lat > 1));
				if (lat == 1)
					check_value("o_spi_sck", spi_sck, 32'd0);
			end
		end
		while (!wb_ack);
		// Ack sampled here rose one edge earlier
		check_value("o_wb_ack latency", k - 1, lat);
		check_value("o_spi_cs_n", spi_cs_n, 32'(cs_n));
		#1;
	endtask

	////////////////////////////////////////////////////////////
	// Flash model
	////////////////////////////////////////////////////////////

	// Slots 0..31 carry opcode and address, 32..63 the data word
	always @(posedge clk)
	begin
		if (spi_cs_n)
			slot = 0;
		else if (spi_sck)
		begin
			if (slot < 32)
				hdr = {hdr[30:0], spi_mosi};
			if (slot == 31)
				word = xorshift(32'(hdr[23:0]));
			if (in_user)
				miso_next = !spi_mosi;
			else if (slot >= 32)
				miso_next = word[63 - slot];
			else
				miso_next = 1'b0;
			slot++;
			#1;
			spi_miso = miso_next;
		end
	end

	// Poll the bound checker between clock edges
	always @(negedge clk)
		if (spi_flash_ctrl_inst.chk_inst.fail_count != 0)
			stop_on_error("a bound protocol assertion failed");

	initial
	begin
		logic [ADDR_W-1:0] addr;
		logic [7:0]        ubyte;
		reset    = 1'b1;
		wb_cyc   = 1'b0;
		wb_stb   = 1'b0;
		cfg_stb  = 1'b0;
		wb_we    = 1'b0;
		wb_addr  = '0;
		wb_wdata = '0;
		spi_miso = 1'b0;
		in_user  = 1'b0;
		repeat (4) @(posedge clk);
		#1;
		reset  = 1'b0;
		wb_cyc = 1'b1;
		// Random reads checked against the data word and the header seen by the flash
		repeat (4)
		begin
			addr = ADDR_W'(next_rand());
			bus_xfer(1'b0, 1'b0, addr, '0, READ_LEN + 1, 1'b1);
			check_value("o_wb_data", wb_rdata, xorshift(32'({addr, 2'b00})));
			check_value("flash header", hdr, {CMD_READ, 24'({addr, 2'b00})});
		end
		// One user byte answered with its complement
		in_user = 1'b1;
		ubyte   = 8'(next_rand());
		bus_xfer(1'b1, 1'b1, '0, {24'd0, ubyte}, USER_LEN + 1, 1'b0);
		check_value("o_wb_data", wb_rdata, {24'd0, ~ubyte});
		// Memory read and write in user mode answer at once
		bus_xfer(1'b0, 1'b0, addr, '0, 1, 1'b0);
		bus_xfer(1'b0, 1'b1, addr, next_rand(), 1, 1'b0);
		// Leave user mode
		bus_xfer(1'b1, 1'b1, '0, 32'h0000_0100, 1, 1'b1);
		in_user = 1'b0;
		addr = ADDR_W'(next_rand());
		bus_xfer(1'b0, 1'b0, addr, '0, READ_LEN + 1, 1'b1);
		check_value("o_wb_data", wb_rdata, xorshift(32'({addr, 2'b00})));
		// Abort a read halfway through the address
		issue_request(1'b0, 1'b0, ADDR_W'(next_rand()), '0);
		repeat (20) @(posedge clk);
		#1;
		wb_cyc = 1'b0;
		@(posedge clk);
		#1;
		wb_cyc = 1'b1;
		@(posedge clk);
		check_value("o_spi_cs_n", spi_cs_n, 32'd1);
		check_value("o_wb_stall", wb_stall, 32'd0);
		#1;
		addr = ADDR_W'(next_rand());
		bus_xfer(1'b0, 1'b0, addr, '0, READ_LEN + 1, 1'b1);
		check_value("o_wb_data", wb_rdata, xorshift(32'({addr, 2'b00})));
		repeat (2) @(posedge clk);
		// Let the properties of the last edge settle
		#1;
		if (spi_flash_ctrl_inst.chk_inst.fail_count != 0)
			stop_on_error("a bound protocol assertion failed");
		else
		begin
			$display("test passed");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== compile.f ====
flash_pkg.sv
flash_seq.sv
flash_shift.sv
spi_flash_ctrl.sv
spi_flash_ctrl_chk.sv
tb_spi_flash_ctrl.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the SPI flash controller testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_spi_flash_ctrl -f compile.f -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

# Raised error limit keeps bound assertion failures from ending the run early
./obj_dir/Vtb_spi_flash_ctrl +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "test failed" "$LOG"; then
	exit 1
fi
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi
exit 0
